//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// one machine word, also the instruction width
`define CPU_XLEN 32

`define CPU_NREG 32

`define CPU_REG_AW 5

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADDU,
    OP_SUBU,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI
  } alu_op_e;

  typedef struct packed {
    alu_op_e                op;
    logic [`CPU_REG_AW-1:0] rs;
    logic [`CPU_REG_AW-1:0] rt;
    logic [`CPU_REG_AW-1:0] waddr;
    logic                   wreg;
    logic                   use_rs;
    logic                   use_rt;
    logic                   use_imm;
    logic [`CPU_XLEN-1:0]   imm;    // sign or zero extended by opcode
  } dec_t;

  // the second instruction sits at pc + 4
  typedef struct packed {
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] inst_1;
    logic [`CPU_XLEN-1:0] inst_2;
  } fetch_pair_t;

  typedef struct packed {
    logic                 valid;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] inst;
    dec_t                 dec;
  } slot_t;

  typedef struct packed {
    logic                   wreg;
    logic [`CPU_REG_AW-1:0] waddr;
    logic [`CPU_XLEN-1:0]   wdata;
  } fwd_t;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_XLEN-1:0]   pc;
    logic [`CPU_XLEN-1:0]   inst;
    logic                   wreg;
    logic [`CPU_REG_AW-1:0] waddr;
    logic [`CPU_XLEN-1:0]   wdata;
  } commit_t;

endpackage

//--- rtl/inst_decode.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module inst_decode (
  input  logic [`CPU_XLEN-1:0] inst_i,
  output cpu_pkg::dec_t        dec_o
);
  import cpu_pkg::*;

  localparam logic [5:0] OPC_SPECIAL = 6'b000000;
  localparam logic [5:0] OPC_ADDIU   = 6'b001001;
  localparam logic [5:0] OPC_ORI     = 6'b001101;
  localparam logic [5:0] OPC_LUI     = 6'b001111;

  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUBU = 6'b100011;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_XOR  = 6'b100110;

  logic [5:0]             opcode;
  logic [5:0]             funct;
  logic [`CPU_REG_AW-1:0] rd;
  logic [`CPU_XLEN-1:0]   imm_sext;
  logic [`CPU_XLEN-1:0]   imm_zext;

  assign opcode   = inst_i[31:26];
  assign funct    = inst_i[5:0];
  assign rd       = inst_i[15:11];
  assign imm_sext = {{(`CPU_XLEN-16){inst_i[15]}}, inst_i[15:0]};
  assign imm_zext = {{(`CPU_XLEN-16){1'b0}}, inst_i[15:0]};

  always_comb begin
    dec_o    = '0;
    dec_o.op = OP_NOP;
    dec_o.rs = inst_i[25:21];
    dec_o.rt = inst_i[20:16];
    case (opcode)
      OPC_SPECIAL: begin
        dec_o.waddr  = rd;
        dec_o.use_rs = 1'b1;
        dec_o.use_rt = 1'b1;
        case (funct)
          FN_ADDU: dec_o.op = OP_ADDU;
          FN_SUBU: dec_o.op = OP_SUBU;
          FN_AND:  dec_o.op = OP_AND;
          FN_OR:   dec_o.op = OP_OR;
          FN_XOR:  dec_o.op = OP_XOR;
          default: begin
            dec_o.use_rs = 1'b0;  // unknown funct retires as a no-op
            dec_o.use_rt = 1'b0;
          end
        endcase
        dec_o.wreg = (dec_o.op != OP_NOP);
      end
      OPC_ADDIU: begin
        dec_o.op      = OP_ADDU;
        dec_o.waddr   = dec_o.rt;
        dec_o.wreg    = 1'b1;
        dec_o.use_rs  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_sext;
      end
      OPC_ORI: begin
        dec_o.op      = OP_OR;
        dec_o.waddr   = dec_o.rt;
        dec_o.wreg    = 1'b1;
        dec_o.use_rs  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_zext;
      end
      OPC_LUI: begin
        dec_o.op      = OP_LUI;  // the lane shifts the immediate into the upper half
        dec_o.waddr   = dec_o.rt;
        dec_o.wreg    = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_zext;
      end
      default: begin
        dec_o.op = OP_NOP;
      end
    endcase
    if (dec_o.waddr == '0)
      dec_o.wreg = 1'b0;  // r0 is hardwired to zero
  end

endmodule

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module issue_ctrl (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  cpu_pkg::fetch_pair_t fetch_pair_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  output cpu_pkg::slot_t       slot_1_o,
  output cpu_pkg::slot_t       slot_2_o
);
  import cpu_pkg::*;

  typedef enum logic {
    ISSUE_PAIR,
    ISSUE_SECOND
  } issue_state_e;

  issue_state_e state_q;
  issue_state_e state_d;
  dec_t         dec_1;
  dec_t         dec_2;
  slot_t        pend_1_q;
  slot_t        pend_2_q;
  slot_t        slot_1_d;
  slot_t        slot_2_d;
  logic         split_q;
  logic         ready_q;
  logic         accept;
  logic         raw_hazard;
  logic         issue_split;

  inst_decode u_dec_1 (
    .inst_i (fetch_pair_i.inst_1),
    .dec_o  (dec_1)
  );

  inst_decode u_dec_2 (
    .inst_i (fetch_pair_i.inst_2),
    .dec_o  (dec_2)
  );

  assign accept        = fetch_valid_i & ready_q;
  assign fetch_ready_o = ready_q;
  assign issue_split   = (state_q == ISSUE_PAIR) & pend_1_q.valid & split_q;

  // the second instruction reads a register that the first one writes
  assign raw_hazard = dec_1.wreg &
                      ((dec_2.use_rs & (dec_2.rs == dec_1.waddr)) |
                       (dec_2.use_rt & (dec_2.rt == dec_1.waddr)));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pend_1_q.valid <= 1'b0;
      pend_2_q.valid <= 1'b0;
      split_q        <= 1'b0;
    end else if (accept) begin
      pend_1_q <= '{valid: 1'b1, pc: fetch_pair_i.pc, inst: fetch_pair_i.inst_1, dec: dec_1};
      pend_2_q <= '{valid: 1'b1, pc: fetch_pair_i.pc + `CPU_XLEN'd4,
                    inst: fetch_pair_i.inst_2, dec: dec_2};
      split_q  <= raw_hazard;
    end else if (!issue_split) begin
      pend_1_q.valid <= 1'b0;  // keep the second one while it waits for lane 2
      pend_2_q.valid <= 1'b0;
    end
  end

  always_comb begin
    slot_1_d = pend_1_q;
    slot_2_d = pend_2_q;
    state_d  = ISSUE_PAIR;
    if (state_q == ISSUE_SECOND) begin
      slot_1_d.valid = 1'b0;
    end else if (issue_split) begin
      slot_2_d.valid = 1'b0;
      state_d        = ISSUE_SECOND;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q        <= ISSUE_PAIR;
      ready_q        <= 1'b0;
      slot_1_o.valid <= 1'b0;
      slot_2_o.valid <= 1'b0;
    end else begin
      state_q  <= state_d;
      ready_q  <= !(accept & raw_hazard);  // a split pair blocks fetch for one cycle
      slot_1_o <= slot_1_d;
      slot_2_o <= slot_2_d;
    end
  end

  a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    fetch_valid_i && !fetch_ready_o |=> $stable(fetch_pair_i));

endmodule

//--- rtl/exec_lane.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module exec_lane (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  cpu_pkg::slot_t         slot_i,
  output logic [`CPU_REG_AW-1:0] rf_raddr_1_o,
  output logic [`CPU_REG_AW-1:0] rf_raddr_2_o,
  input  logic [`CPU_XLEN-1:0]   rf_rdata_1_i,
  input  logic [`CPU_XLEN-1:0]   rf_rdata_2_i,
  input  cpu_pkg::fwd_t          fwd_lane_1_i,
  input  cpu_pkg::fwd_t          fwd_lane_2_i,
  output cpu_pkg::fwd_t          fwd_o,
  output cpu_pkg::commit_t       commit_o
);
  import cpu_pkg::*;

  slot_t                ex_slot_q;
  logic [`CPU_XLEN-1:0] id_op_a;
  logic [`CPU_XLEN-1:0] id_op_b;
  logic [`CPU_XLEN-1:0] ex_a_q;
  logic [`CPU_XLEN-1:0] ex_b_q;
  logic [`CPU_XLEN-1:0] ex_result;
  commit_t              wb_q;

  // lane 2 carries the younger instruction of a pair so its EX result wins
  function automatic logic [`CPU_XLEN-1:0] pick_operand(
    input logic [`CPU_REG_AW-1:0] addr,
    input logic [`CPU_XLEN-1:0]   rf_data,
    input fwd_t                   fwd_1,
    input fwd_t                   fwd_2
  );
    logic [`CPU_XLEN-1:0] data;
    if (addr == '0)
      data = '0;
    else if (fwd_2.wreg && fwd_2.waddr == addr)
      data = fwd_2.wdata;
    else if (fwd_1.wreg && fwd_1.waddr == addr)
      data = fwd_1.wdata;
    else
      data = rf_data;  // WB results come through the register file bypass
    return data;
  endfunction

  assign rf_raddr_1_o = slot_i.dec.rs;
  assign rf_raddr_2_o = slot_i.dec.rt;

  assign id_op_a = pick_operand(slot_i.dec.rs, rf_rdata_1_i, fwd_lane_1_i, fwd_lane_2_i);
  assign id_op_b = slot_i.dec.use_imm ? slot_i.dec.imm :
                   pick_operand(slot_i.dec.rt, rf_rdata_2_i, fwd_lane_1_i, fwd_lane_2_i);

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      ex_slot_q.valid <= 1'b0;
    else
      ex_slot_q <= slot_i;
  end

  always_ff @(posedge clk) begin
    ex_a_q <= id_op_a;
    ex_b_q <= id_op_b;
  end

  always_comb begin
    case (ex_slot_q.dec.op)
      OP_ADDU: ex_result = ex_a_q + ex_b_q;
      OP_SUBU: ex_result = ex_a_q - ex_b_q;
      OP_AND:  ex_result = ex_a_q & ex_b_q;
      OP_OR:   ex_result = ex_a_q | ex_b_q;
      OP_XOR:  ex_result = ex_a_q ^ ex_b_q;
      OP_LUI:  ex_result = {ex_b_q[15:0], 16'h0000};
      default: ex_result = '0;
    endcase
  end

  always_comb begin
    fwd_o.wreg  = ex_slot_q.valid & ex_slot_q.dec.wreg;
    fwd_o.waddr = ex_slot_q.dec.waddr;
    fwd_o.wdata = ex_result;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wb_q.valid <= 1'b0;
      wb_q.wreg  <= 1'b0;
    end else begin
      wb_q.valid <= ex_slot_q.valid;
      wb_q.pc    <= ex_slot_q.pc;
      wb_q.inst  <= ex_slot_q.inst;
      wb_q.wreg  <= fwd_o.wreg;
      wb_q.waddr <= ex_slot_q.dec.waddr;
      wb_q.wdata <= ex_result;
    end
  end

  assign commit_o = wb_q;

  // decode drops r0 writes two stages earlier
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    commit_o.wreg |-> commit_o.waddr != '0);

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  cpu_pkg::commit_t       wb_1_i,
  input  cpu_pkg::commit_t       wb_2_i,
  input  logic [`CPU_REG_AW-1:0] raddr_i [4],
  output logic [`CPU_XLEN-1:0]   rdata_o [4]
);
  import cpu_pkg::*;

  logic [`CPU_XLEN-1:0] regs_q [`CPU_NREG];
  logic                 we_1;
  logic                 we_2;

  assign we_1 = wb_1_i.valid & wb_1_i.wreg;
  assign we_2 = wb_2_i.valid & wb_2_i.wreg;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CPU_NREG; i++)
        regs_q[i] <= '0;
    end else begin
      if (we_1)
        regs_q[wb_1_i.waddr] <= wb_1_i.wdata;
      if (we_2)
        regs_q[wb_2_i.waddr] <= wb_2_i.wdata;  // younger lane lands last
    end
  end

  // write-through keeps the same lane order as the write port
  always_comb begin
    for (int r = 0; r < 4; r++) begin
      if (raddr_i[r] == '0)
        rdata_o[r] = '0;
      else if (we_2 && wb_2_i.waddr == raddr_i[r])
        rdata_o[r] = wb_2_i.wdata;
      else if (we_1 && wb_1_i.waddr == raddr_i[r])
        rdata_o[r] = wb_1_i.wdata;
      else
        rdata_o[r] = regs_q[raddr_i[r]];
    end
  end

  // lane 2 must hold the younger instruction for the write priority to be right
  a_lane_order: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_1_i.valid && wb_2_i.valid |-> wb_2_i.pc >= wb_1_i.pc);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  cpu_pkg::fetch_pair_t fetch_pair_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  output cpu_pkg::commit_t     commit_1_o,
  output cpu_pkg::commit_t     commit_2_o
);
  import cpu_pkg::*;

  slot_t                 slot_1;
  slot_t                 slot_2;
  fwd_t                  fwd_1;
  fwd_t                  fwd_2;
  wire [`CPU_REG_AW-1:0] rf_raddr [4];  // lane 1 rs, rt then lane 2 rs, rt
  wire [`CPU_XLEN-1:0]   rf_rdata [4];

  issue_ctrl u_issue (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_pair_i  (fetch_pair_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .slot_1_o      (slot_1),
    .slot_2_o      (slot_2)
  );

  exec_lane u_lane_1 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .slot_i       (slot_1),
    .rf_raddr_1_o (rf_raddr[0]),
    .rf_raddr_2_o (rf_raddr[1]),
    .rf_rdata_1_i (rf_rdata[0]),
    .rf_rdata_2_i (rf_rdata[1]),
    .fwd_lane_1_i (fwd_1),
    .fwd_lane_2_i (fwd_2),
    .fwd_o        (fwd_1),
    .commit_o     (commit_1_o)
  );

  exec_lane u_lane_2 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .slot_i       (slot_2),
    .rf_raddr_1_o (rf_raddr[2]),
    .rf_raddr_2_o (rf_raddr[3]),
    .rf_rdata_1_i (rf_rdata[2]),
    .rf_rdata_2_i (rf_rdata[3]),
    .fwd_lane_1_i (fwd_1),
    .fwd_lane_2_i (fwd_2),
    .fwd_o        (fwd_2),
    .commit_o     (commit_2_o)
  );

  // commits double as the write-back ports
  regfile u_regfile (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wb_1_i  (commit_1_o),
    .wb_2_i  (commit_2_o),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata)
  );

endmodule

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [5:0] OPC_R     = 6'h00;
localparam logic [5:0] OPC_ADDIU = 6'h09;
localparam logic [5:0] OPC_ORI   = 6'h0d;
localparam logic [5:0] OPC_LUI   = 6'h0f;
localparam logic [5:0] FN_ADDU   = 6'h21;
localparam logic [5:0] FN_SUBU   = 6'h23;
localparam logic [5:0] FN_AND    = 6'h24;
localparam logic [5:0] FN_OR     = 6'h25;
localparam logic [5:0] FN_XOR    = 6'h26;

logic [`CPU_XLEN-1:0] arch_regs [`CPU_NREG] = '{default: '0};  // state in program order

function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
  return {OPC_R, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rt, rs,
                                       input logic [15:0] imm);
  return {opc, rs, rt, imm};
endfunction

function automatic logic is_alu_funct(input logic [5:0] fn);
  return (fn == FN_ADDU) || (fn == FN_SUBU) || (fn == FN_AND) ||
         (fn == FN_OR) || (fn == FN_XOR);
endfunction

// true when the instruction takes register r as a source operand
function automatic logic reads_reg(input logic [31:0] inst, input logic [4:0] r);
  case (inst[31:26])
    OPC_R: return is_alu_funct(inst[5:0]) && (inst[25:21] == r || inst[20:16] == r);
    OPC_ADDIU, OPC_ORI: return inst[25:21] == r;
    default: return 1'b0;
  endcase
endfunction

function automatic commit_t ref_commit(input logic [31:0] pc, input logic [31:0] inst);
  commit_t     c;
  logic [31:0] a;
  logic [31:0] b;
  a = arch_regs[inst[25:21]];
  b = arch_regs[inst[20:16]];
  c = '0;
  c.valid = 1'b1;
  c.pc    = pc;
  c.inst  = inst;
  c.wreg  = 1'b1;
  c.waddr = inst[20:16];
  case (inst[31:26])
    OPC_R: begin
      c.waddr = inst[15:11];
      case (inst[5:0])
        FN_ADDU: c.wdata = a + b;
        FN_SUBU: c.wdata = a - b;
        FN_AND:  c.wdata = a & b;
        FN_OR:   c.wdata = a | b;
        FN_XOR:  c.wdata = a ^ b;
        default: c.wreg = 1'b0;
      endcase
    end
    OPC_ADDIU: c.wdata = a + {{16{inst[15]}}, inst[15:0]};
    OPC_ORI:   c.wdata = a | {16'h0000, inst[15:0]};
    OPC_LUI:   c.wdata = {inst[15:0], 16'h0000};
    default:   c.wreg = 1'b0;
  endcase
  if (c.waddr == 5'd0)
    c.wreg = 1'b0;
  if (c.wreg)
    arch_regs[c.waddr] = c.wdata;
  return c;
endfunction

// small register range so that hazards come up often
function automatic logic [31:0] rand_inst();
  logic [4:0]  rd;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [15:0] imm;
  rd  = 5'($urandom_range(7));
  rs  = 5'($urandom_range(7));
  rt  = 5'($urandom_range(7));
  imm = 16'($urandom);
  case ($urandom_range(9))
    0: return r_type(FN_ADDU, rd, rs, rt);
    1: return r_type(FN_SUBU, rd, rs, rt);
    2: return r_type(FN_AND, rd, rs, rt);
    3: return r_type(FN_OR, rd, rs, rt);
    4: return r_type(FN_XOR, rd, rs, rt);
    5: return i_type(OPC_ADDIU, rt, rs, imm);
    6: return i_type(OPC_ORI, rt, rs, imm);
    7: return i_type(OPC_LUI, rt, 5'd0, imm);
    8: return {6'h23, rs, rt, imm};  // load opcode, not part of the subset
    default: return r_type(6'h2a, rd, rs, rt);
  endcase
endfunction

`endif

//--- test/tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_top;
  import cpu_pkg::*;

  `include "tb_program.svh"

  localparam int DIRECTED_PAIRS = 14;
  localparam int RANDOM_PAIRS   = 300;
  localparam int TIMEOUT_CYCLES = (DIRECTED_PAIRS + RANDOM_PAIRS) * 2 + 50;
  localparam int COMMIT_LAT     = 4;  // accept edge to the edge that samples the commit

  logic        clk;
  logic        rst_n_i;
  fetch_pair_t fetch_pair_i;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  commit_t     commit_1_o;
  commit_t     commit_2_o;

  commit_t     exp_q[$];
  int          lane_q[$];
  int          due_q[$];
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] pc_next;
  logic        seen_edge = 1'b0;
  logic        rst_prev = 1'b0;
  logic        split_prev = 1'b0;

  cpu_top u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_pair_i  (fetch_pair_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .commit_1_o    (commit_1_o),
    .commit_2_o    (commit_2_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_expected(input commit_t c, input int lane, input int due);
    exp_q.push_back(c);
    lane_q.push_back(lane);
    due_q.push_back(due);
  endtask

  task automatic match_commit(input commit_t got, input int lane);
    commit_t e;
    string   n;
    n = $sformatf("commit_%0d_o", lane);
    if (exp_q.size() == 0) begin
      errors++;
      $display("lane %0d committed pc %h at %0t ns with nothing outstanding", lane, got.pc, $time);
    end else begin
      e = exp_q.pop_front();
      check_value({n, " lane"}, lane, lane_q.pop_front());
      check_value({n, " cycle"}, cyc, due_q.pop_front());
      check_value({n, ".pc"}, got.pc, e.pc);
      check_value({n, ".inst"}, got.inst, e.inst);
      check_value({n, ".wreg"}, 32'(got.wreg), 32'(e.wreg));
      if (e.wreg) begin  // no destination to compare without a write
        check_value({n, ".waddr"}, 32'(got.waddr), 32'(e.waddr));
        check_value({n, ".wdata"}, got.wdata, e.wdata);
      end
    end
  endtask

  // expected values are computed at the accept edge, in program order
  always @(posedge clk) begin
    commit_t exp_c;
    logic    split;
    if (!rst_n_i) begin
      if (seen_edge) begin
        check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
        check_value("commit_1_o.valid", 32'(commit_1_o.valid), 32'd0);
        check_value("commit_2_o.valid", 32'(commit_2_o.valid), 32'd0);
      end
      rst_prev   = 1'b0;
      split_prev = 1'b0;
    end else begin
      check_value("fetch_ready_o", 32'(fetch_ready_o), 32'(rst_prev && !split_prev));
      split = 1'b0;
      if (fetch_valid_i && fetch_ready_o) begin
        exp_c = ref_commit(fetch_pair_i.pc, fetch_pair_i.inst_1);
        split = exp_c.wreg && reads_reg(fetch_pair_i.inst_2, exp_c.waddr);
        push_expected(exp_c, 1, cyc + COMMIT_LAT);
        exp_c = ref_commit(fetch_pair_i.pc + 32'd4, fetch_pair_i.inst_2);
        push_expected(exp_c, 2, split ? cyc + COMMIT_LAT + 1 : cyc + COMMIT_LAT);
      end
      if (commit_1_o.valid)
        match_commit(commit_1_o, 1);  // older lane first
      if (commit_2_o.valid)
        match_commit(commit_2_o, 2);
      rst_prev   = 1'b1;
      split_prev = split;
    end
    seen_edge = 1'b1;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYCLES) begin
      $display("timeout: the pipeline stalled, run stopped after %0d cycles", cyc);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic send_pair(input logic [31:0] i1, input logic [31:0] i2);
    fetch_pair_i  <= '{pc: pc_next, inst_1: i1, inst_2: i2};
    fetch_valid_i <= 1'b1;
    @(posedge clk);
    while (!fetch_ready_o)
      @(posedge clk);
    pc_next = pc_next + 32'd8;
  endtask

  task automatic idle_cycle();
    fetch_valid_i <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    int drain;
    void'($urandom(96));
    rst_n_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pair_i  = '0;
    pc_next       = 32'h0000_1000;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (4) idle_cycle();

    // independent pairs over every operation
    send_pair(i_type(OPC_ADDIU, 5'd1, 5'd0, 16'h1234), i_type(OPC_LUI, 5'd2, 5'd0, 16'h8001));
    send_pair(i_type(OPC_ORI, 5'd3, 5'd0, 16'hf0f0), i_type(OPC_ADDIU, 5'd4, 5'd0, 16'hfffb));
    send_pair(r_type(FN_ADDU, 5'd5, 5'd1, 5'd2), r_type(FN_SUBU, 5'd6, 5'd3, 5'd4));
    send_pair(r_type(FN_AND, 5'd7, 5'd2, 5'd3), r_type(FN_OR, 5'd8, 5'd1, 5'd4));
    send_pair(r_type(FN_XOR, 5'd9, 5'd5, 5'd6), i_type(OPC_ORI, 5'd10, 5'd1, 16'h00ff));

    // dependent inside the pair, so the pair is split
    send_pair(r_type(FN_ADDU, 5'd11, 5'd1, 5'd2), r_type(FN_SUBU, 5'd12, 5'd11, 5'd3));
    send_pair(i_type(OPC_ADDIU, 5'd13, 5'd12, 16'h0007), r_type(FN_XOR, 5'd14, 5'd13, 5'd1));

    // same destination on both lanes, then reads through EX and WB
    send_pair(i_type(OPC_ADDIU, 5'd15, 5'd0, 16'h0001), i_type(OPC_ADDIU, 5'd15, 5'd0, 16'h0002));
    send_pair(r_type(FN_ADDU, 5'd16, 5'd15, 5'd15), r_type(FN_OR, 5'd17, 5'd15, 5'd0));
    send_pair(i_type(OPC_ADDIU, 5'd18, 5'd15, 16'h0003), i_type(OPC_ADDIU, 5'd19, 5'd0, 16'h0004));
    send_pair(r_type(FN_ADDU, 5'd20, 5'd16, 5'd18), r_type(FN_SUBU, 5'd21, 5'd17, 5'd19));

    // r0 writes and encodings outside the subset
    send_pair(i_type(OPC_ADDIU, 5'd0, 5'd1, 16'h0005), r_type(FN_ADDU, 5'd0, 5'd1, 5'd2));
    send_pair(r_type(FN_ADDU, 5'd22, 5'd0, 5'd1), 32'hfc00_0000);
    send_pair(r_type(6'h3f, 5'd23, 5'd1, 5'd2), r_type(FN_OR, 5'd24, 5'd0, 5'd0));

    for (int p = 0; p < RANDOM_PAIRS; p++) begin
      if ($urandom_range(3) == 0)
        idle_cycle();
      send_pair(rand_inst(), rand_inst());
    end
    fetch_valid_i <= 1'b0;

    drain = 0;
    while (exp_q.size() != 0 && drain < 20) begin
      @(posedge clk);
      drain++;
    end
    repeat (5) @(posedge clk);  // any stray commit shows up here
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected commits never came out of the pipeline", exp_q.size());
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
+incdir+test
rtl/cpu_pkg.sv
rtl/inst_decode.sv
rtl/issue_ctrl.sv
rtl/exec_lane.sv
rtl/regfile.sv
rtl/cpu_top.sv
test/tb_cpu_top.sv
